//--- project.f
source/fpsu_pkg.sv
source/fpsu_issue.sv
source/operand_forward.sv
source/fp32_add_lane.sv
source/fp32_compare.sv
source/fp_exception_report.sv
source/fpsu_top.sv
tests/fpsu_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module fpsu_tb -f project.f \
  --Mdir obj_dir -o fpsu_sim
./obj_dir/fpsu_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
  echo "simulation run ok"
else
  echo "simulation run reported errors"
  exit 1
fi

//--- source/fp32_add_lane.sv
// round to nearest even only; subnormal inputs and results flush to zero, NaN results are 0x7FC00000
`timescale 1ns/1ps
module fp32_add_lane (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en,
  input  logic                 is_sub,
  input  fpsu_pkg::lane_t      a,
  input  fpsu_pkg::lane_t      b,
  output fpsu_pkg::lane_t      sum,
  output fpsu_pkg::exc_flags_t flags
);

  logic        sa, sb, eff_sub, a_big;
  logic        a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
  logic [30:0] a_mag, b_mag;
  logic [7:0]  exp_big, exp_diff;
  logic [23:0] m_big, m_small;
  logic [5:0]  sh;
  logic [49:0] wide;
  logic [27:0] big_ext, small_ext;

  logic        s1_en, s1_nan, s1_inf, s1_sign, s1_zsign;
  logic [7:0]  s1_exp;
  logic [27:0] s1_sum;  // carry, hidden bit, 23 fraction bits, guard, round, sticky

  logic [4:0]           lz;
  logic [27:0]          norm;
  logic signed [9:0]    exp_n, exp_r;
  logic                 grd, stk, rnd_up;
  logic [23:0]          mant_r;
  fpsu_pkg::lane_t      sum_n;
  fpsu_pkg::exc_flags_t flags_n;

  always_comb begin
    sa     = a[31];
    sb     = b[31] ^ is_sub;
    a_zero = a[30:23] == 8'd0;  // subnormals too
    b_zero = b[30:23] == 8'd0;
    a_inf  = (a[30:23] == 8'hff) && (a[22:0] == '0);
    b_inf  = (b[30:23] == 8'hff) && (b[22:0] == '0);
    a_nan  = (a[30:23] == 8'hff) && (a[22:0] != '0);
    b_nan  = (b[30:23] == 8'hff) && (b[22:0] != '0);
    a_mag  = a_zero ? '0 : a[30:0];
    b_mag  = b_zero ? '0 : b[30:0];
    a_big  = a_mag >= b_mag;
    eff_sub = sa ^ sb;

    exp_big  = a_big ? a_mag[30:23] : b_mag[30:23];
    exp_diff = exp_big - (a_big ? b_mag[30:23] : a_mag[30:23]);
    m_big    = a_big ? {~a_zero, a_mag[22:0]} : {~b_zero, b_mag[22:0]};
    m_small  = a_big ? {~b_zero, b_mag[22:0]} : {~a_zero, a_mag[22:0]};

    // clamp keeps a far-off operand alive in the sticky bit
    sh        = (exp_diff > 8'd49) ? 6'd49 : exp_diff[5:0];
    wide      = {m_small, 26'd0} >> sh;
    big_ext   = {1'b0, m_big, 3'b000};
    small_ext = {1'b0, wide[49:24], |wide[23:0]};
  end

  always_ff @(posedge clk) begin
    if (rst) s1_en <= 1'b0;
    else s1_en <= en;
    s1_nan   <= a_nan | b_nan | (a_inf & b_inf & eff_sub);
    s1_inf   <= a_inf | b_inf;
    s1_sign  <= a_big ? sa : sb;
    s1_zsign <= sa & sb;  // exact zero is -0 only for -0 + -0
    s1_exp   <= exp_big;
    s1_sum   <= eff_sub ? big_ext - small_ext : big_ext + small_ext;
  end

  always_comb begin
    lz = 5'd0;
    for (int i = 0; i < 28; i++) begin
      if (s1_sum[i]) lz = 5'(27 - i);
    end
    norm   = s1_sum << lz;
    grd    = norm[3];
    stk    = |norm[2:0];
    rnd_up = grd & (stk | norm[4]);  // ties go to even
    mant_r = {1'b0, norm[26:4]} + 24'(rnd_up);
    exp_n  = $signed({2'b00, s1_exp}) + 10'sd1 - $signed({5'd0, lz});
    exp_r  = exp_n + $signed({9'd0, mant_r[23]});

    flags_n = '0;
    if (s1_nan) begin
      sum_n           = fpsu_pkg::QNAN;
      flags_n.invalid = 1'b1;
    end else if (s1_inf) begin
      sum_n = {s1_sign, 8'hff, 23'd0};
    end else if (s1_sum == '0) begin
      sum_n = {s1_zsign, 31'd0};
    end else if (exp_r >= 10'sd255) begin
      sum_n            = {s1_sign, 8'hff, 23'd0};
      flags_n.overflow = 1'b1;
      flags_n.inexact  = 1'b1;
    end else if (exp_r <= 10'sd0) begin
      sum_n             = {s1_sign, 31'd0};  // flushed
      flags_n.underflow = 1'b1;
      flags_n.inexact   = 1'b1;
    end else begin
      sum_n           = {s1_sign, exp_r[7:0], mant_r[22:0]};
      flags_n.inexact = grd | stk;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || !s1_en) begin
      sum   <= '0;
      flags <= '0;
    end else begin
      sum   <= sum_n;
      flags <= flags_n;
    end
  end

endmodule

//--- source/fp32_compare.sv
// subnormals compare as zero; any NaN operand gives unordered and raises invalid
`timescale 1ns/1ps
module fp32_compare (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en,
  input  fpsu_pkg::lane_t      a,
  input  fpsu_pkg::lane_t      b,
  output fpsu_pkg::cmp_flags_t cmp,
  output logic                 invalid
);

  logic                 a_nan, b_nan;
  logic [30:0]          a_mag, b_mag;
  logic                 s1_en, s1_unord, s1_both_zero, s1_sa, s1_sb, s1_lt, s1_eq;
  fpsu_pkg::cmp_flags_t cmp_n;

  always_comb begin
    a_nan = (a[30:23] == 8'hff) && (a[22:0] != '0);
    b_nan = (b[30:23] == 8'hff) && (b[22:0] != '0);
    a_mag = (a[30:23] == 8'd0) ? '0 : a[30:0];
    b_mag = (b[30:23] == 8'd0) ? '0 : b[30:0];
  end

  always_ff @(posedge clk) begin
    if (rst) s1_en <= 1'b0;
    else s1_en <= en;
    s1_unord     <= a_nan | b_nan;
    s1_both_zero <= (a_mag == '0) && (b_mag == '0);  // +0 == -0
    s1_sa        <= a[31];
    s1_sb        <= b[31];
    s1_lt        <= a_mag < b_mag;
    s1_eq        <= a_mag == b_mag;
  end

  always_comb begin
    cmp_n = '0;
    if (s1_unord) cmp_n.unord = 1'b1;
    else if (s1_both_zero) cmp_n.eq = 1'b1;
    else if (s1_sa != s1_sb) begin
      cmp_n.lt = s1_sa;
      cmp_n.gt = s1_sb;
    end else if (s1_eq) cmp_n.eq = 1'b1;
    else begin
      cmp_n.lt = s1_lt ^ s1_sa;  // magnitude order flips for negatives
      cmp_n.gt = ~(s1_lt ^ s1_sa);
    end
  end

  always_ff @(posedge clk) begin
    if (rst || !s1_en) begin
      cmp     <= '0;
      invalid <= 1'b0;
    end else begin
      cmp     <= cmp_n;
      invalid <= s1_unord;
    end
  end

endmodule

//--- source/fp_exception_report.sv
// combinational; priority is invalid, overflow, underflow, inexact and masked flags never retire
`timescale 1ns/1ps
module fp_exception_report (
  input  fpsu_pkg::exc_flags_t flags0,
  input  fpsu_pkg::exc_flags_t flags1,
  input  fpsu_pkg::fp_csr_t    csr,
  output logic                 ret_en,
  output fpsu_pkg::exc_code_e  ret_code
);

  fpsu_pkg::exc_flags_t raised;
  fpsu_pkg::exc_flags_t enabled;

  always_comb begin
    raised  = flags0 | flags1;
    enabled = raised & csr;  // csr bits line up with the flags
    ret_en  = |enabled;
    if (enabled.invalid) begin
      ret_code = fpsu_pkg::EXC_INVALID;
    end else if (enabled.overflow) begin
      ret_code = fpsu_pkg::EXC_OVERFLOW;
    end else if (enabled.underflow) begin
      ret_code = fpsu_pkg::EXC_UNDERFLOW;
    end else if (enabled.inexact) begin
      ret_code = fpsu_pkg::EXC_INEXACT;
    end else begin
      ret_code = fpsu_pkg::EXC_NONE;
    end
  end

endmodule

//--- source/fpsu_issue.sv
// one request in flight over four-phase req/ack; request must stay stable until ack rises
`timescale 1ns/1ps
module fpsu_issue (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  output logic                 ack,
  input  fpsu_pkg::fop_e       op,
  output logic                 capture,
  output fpsu_pkg::ctrl_t      ctrl,
  input  fpsu_pkg::vec_t       lane_res,
  input  fpsu_pkg::cmp_flags_t lane_cmp,
  input  logic                 exc_ret_en,
  input  fpsu_pkg::exc_code_e  exc_code,
  output fpsu_pkg::fp_res_t    res
);

  localparam int PIPE_LAT = 3;  // operand capture plus two execute stages

  typedef enum logic [1:0] {IDLE, BUSY, DONE, RELEASE} state_e;

  state_e              state;
  fpsu_pkg::fop_e      op_q;
  logic [PIPE_LAT-1:0] vld;
  logic                known_op;
  fpsu_pkg::fp_res_t   res_n;

  always_comb begin
    known_op = op_q inside {fpsu_pkg::FOP_ADDS, fpsu_pkg::FOP_SUBS, fpsu_pkg::FOP_ADDSP,
                            fpsu_pkg::FOP_SUBSP, fpsu_pkg::FOP_CMPS};
    res_n = '0;
    if (known_op) begin
      res_n.ret_en   = exc_ret_en;
      res_n.ret_code = exc_code;
      if (ctrl.is_cmp) begin
        res_n.cmp = lane_cmp;  // data stays zero
      end else begin
        res_n.data = lane_res;
        if (!ctrl.is_packed) res_n.data[1] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      ack     <= 1'b0;
      capture <= 1'b0;
      vld     <= '0;
      ctrl    <= '0;
      op_q    <= fpsu_pkg::FOP_ADDS;
      res     <= '0;
    end else begin
      capture <= 1'b0;
      vld     <= {vld[PIPE_LAT-2:0], capture};
      case (state)
        IDLE: if (req) begin
          state          <= BUSY;
          capture        <= 1'b1;
          op_q           <= op;
          ctrl.is_sub    <= (op == fpsu_pkg::FOP_SUBS) || (op == fpsu_pkg::FOP_SUBSP);
          ctrl.is_packed <= (op == fpsu_pkg::FOP_ADDSP) || (op == fpsu_pkg::FOP_SUBSP);
          ctrl.is_cmp    <= op == fpsu_pkg::FOP_CMPS;
        end
        BUSY: if (vld[PIPE_LAT-1]) begin
          res   <= res_n;
          ack   <= 1'b1;
          state <= DONE;
        end
        DONE: if (!req) state <= RELEASE;  // hold res while req stays up
        RELEASE: begin
          ack   <= 1'b0;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- source/fpsu_pkg.sv
// shared types for the two-lane single precision unit; forward selectors are 2 bits so at most 3 buses
package fpsu_pkg;

  localparam int LANE_W = 32;
  localparam int LANES  = 2;
  localparam int SRC_W  = 2;  // 0 selects the register value, k selects bus k-1

  typedef enum logic [2:0] {
    FOP_ADDS  = 3'd0,
    FOP_SUBS  = 3'd1,
    FOP_ADDSP = 3'd2,
    FOP_SUBSP = 3'd3,
    FOP_CMPS  = 3'd4
  } fop_e;  // other codes act as no-op

  typedef logic [LANE_W-1:0] lane_t;
  typedef lane_t [LANES-1:0] vec_t;

  localparam lane_t QNAN = 32'h7fc0_0000;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } exc_flags_t;

  typedef enum logic [2:0] {
    EXC_NONE      = 3'd0,
    EXC_INVALID   = 3'd1,
    EXC_OVERFLOW  = 3'd2,
    EXC_UNDERFLOW = 3'd3,
    EXC_INEXACT   = 3'd4
  } exc_code_e;

  // same bit order as exc_flags_t
  typedef struct packed {
    logic invalid_en;
    logic overflow_en;
    logic underflow_en;
    logic inexact_en;
  } fp_csr_t;

  typedef struct packed {
    logic lt;
    logic eq;
    logic gt;
    logic unord;
  } cmp_flags_t;

  typedef struct packed {
    fop_e             op;
    vec_t             a;
    vec_t             b;
    logic [SRC_W-1:0] src_a;
    logic [SRC_W-1:0] src_b;
  } fp_req_t;

  typedef struct packed {
    vec_t       data;
    cmp_flags_t cmp;
    logic       ret_en;
    exc_code_e  ret_code;
  } fp_res_t;

  typedef struct packed {
    logic is_sub;
    logic is_packed;
    logic is_cmp;
  } ctrl_t;

endpackage

//--- source/fpsu_top.sv
// ack rises 4 cycles after req is sampled; fwd_bus entries addressed by the request must be stable
`timescale 1ns/1ps
module fpsu_top #(
  parameter int FWD_COUNT = 3
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           req,
  output logic                           ack,
  input  fpsu_pkg::fp_req_t              request,
  input  fpsu_pkg::vec_t [FWD_COUNT-1:0] fwd_bus,
  input  fpsu_pkg::fp_csr_t              csr,
  output fpsu_pkg::fp_res_t              res
);

  logic                 capture;
  fpsu_pkg::ctrl_t      ctrl;
  fpsu_pkg::vec_t       op_a, op_b;
  fpsu_pkg::vec_t       lane_res;
  fpsu_pkg::exc_flags_t lane0_flags, lane1_flags;
  fpsu_pkg::cmp_flags_t cmp_flags;
  logic                 cmp_invalid;
  logic                 ret_en;
  fpsu_pkg::exc_code_e  ret_code;

  fpsu_issue issue_inst (
    .clk(clk), .rst(rst), .req(req), .ack(ack),
    .op(request.op), .capture(capture), .ctrl(ctrl),
    .lane_res(lane_res), .lane_cmp(cmp_flags),
    .exc_ret_en(ret_en), .exc_code(ret_code), .res(res)
  );

  operand_forward #(.FWD_COUNT(FWD_COUNT)) fwd_inst (
    .clk(clk), .rst(rst), .capture(capture),
    .src_a(request.src_a), .src_b(request.src_b),
    .a(request.a), .b(request.b), .fwd_bus(fwd_bus),
    .op_a(op_a), .op_b(op_b)
  );

  fp32_add_lane lane0_inst (
    .clk(clk), .rst(rst), .en(!ctrl.is_cmp), .is_sub(ctrl.is_sub),
    .a(op_a[0]), .b(op_b[0]), .sum(lane_res[0]), .flags(lane0_flags)
  );

  fp32_add_lane lane1_inst (
    .clk(clk), .rst(rst), .en(ctrl.is_packed), .is_sub(ctrl.is_sub),
    .a(op_a[1]), .b(op_b[1]), .sum(lane_res[1]), .flags(lane1_flags)
  );

  fp32_compare cmp_inst (
    .clk(clk), .rst(rst), .en(ctrl.is_cmp),
    .a(op_a[0]), .b(op_b[0]), .cmp(cmp_flags), .invalid(cmp_invalid)
  );

  // compare invalid rides on lane 0 flags
  fp_exception_report exc_inst (
    .flags0(lane0_flags | {cmp_invalid, 3'b000}), .flags1(lane1_flags),
    .csr(csr), .ret_en(ret_en), .ret_code(ret_code)
  );

endmodule

//--- source/operand_forward.sv
// selector values above FWD_COUNT fall back to the register value
`timescale 1ns/1ps
module operand_forward #(
  parameter int FWD_COUNT = 3
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  capture,
  input  logic [fpsu_pkg::SRC_W-1:0]            src_a,
  input  logic [fpsu_pkg::SRC_W-1:0]            src_b,
  input  fpsu_pkg::vec_t                        a,
  input  fpsu_pkg::vec_t                        b,
  input  fpsu_pkg::vec_t [FWD_COUNT-1:0]        fwd_bus,
  output fpsu_pkg::vec_t                        op_a,
  output fpsu_pkg::vec_t                        op_b
);

  fpsu_pkg::vec_t sel_a, sel_b;

  always_comb begin
    sel_a = a;
    sel_b = b;
    for (int k = 0; k < FWD_COUNT; k++) begin
      if (src_a == fpsu_pkg::SRC_W'(k + 1)) sel_a = fwd_bus[k];
      if (src_b == fpsu_pkg::SRC_W'(k + 1)) sel_b = fwd_bus[k];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      op_a <= '0;
      op_b <= '0;
    end else if (capture) begin
      op_a <= sel_a;
      op_b <= sel_b;
    end
  end

endmodule

//--- tests/fpsu_tb.sv
// one request at a time over req/ack; expected values are hand computed from exactly representable floats
`timescale 1ns/1ps
module fpsu_tb;

  localparam int FWD_COUNT   = 3;
  localparam int ACK_LAT     = 4;
  localparam int HOLD_CYCLES = 2;
  localparam int TIMEOUT     = 50;

  typedef struct packed {
    fpsu_pkg::fp_req_t req;
    fpsu_pkg::fp_csr_t csr;
    fpsu_pkg::fp_res_t exp;
  } test_t;

  logic                           clk = 1'b0;
  logic                           rst;
  logic                           req;
  logic                           ack;
  fpsu_pkg::fp_req_t              request;
  fpsu_pkg::vec_t [FWD_COUNT-1:0] fwd_bus;
  fpsu_pkg::fp_csr_t              csr;
  fpsu_pkg::fp_res_t              res;

  test_t       tests[$];
  string       names[$];
  logic [31:0] lfsr = 32'd66453;
  int          test_errs;
  int          run_count;
  int          failed_tests;
  bit          timed_out;

  fpsu_top #(.FWD_COUNT(FWD_COUNT)) fpsu_inst (
    .clk(clk), .rst(rst), .req(req), .ack(ack),
    .request(request), .fwd_bus(fwd_bus), .csr(csr), .res(res)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hb4bc_d35c) : (s >> 1);  // galois form
  endfunction

  task automatic random_vec(output fpsu_pkg::vec_t v);
    logic [63:0] bits;
    for (int i = 0; i < 64; i++) begin
      lfsr    = lfsr_next(lfsr);
      bits[i] = lfsr[0];
    end
    v = bits;
  endtask

  task automatic check_vec(input string name, input fpsu_pkg::vec_t exp,
                           input fpsu_pkg::vec_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s data: expected %h actual %h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_cmp(input string name, input fpsu_pkg::cmp_flags_t exp,
                           input fpsu_pkg::cmp_flags_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s cmp lt/eq/gt/unord: expected %b actual %b", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_code(input string name, input logic exp_en,
                            input fpsu_pkg::exc_code_e exp_code, input logic act_en,
                            input fpsu_pkg::exc_code_e act_code);
    if (act_en !== exp_en || act_code !== exp_code) begin
      $display("CHECK FAILED %s retire: expected en=%b code=%0d actual en=%b code=%0d",
               name, exp_en, exp_code, act_en, act_code);
      test_errs++;
    end
  endtask

  task automatic check_bit(input string name, input string what, input logic exp,
                           input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %b actual %b", name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_count(input string name, input string what, input int exp,
                             input int act);
    if (act != exp) begin
      $display("CHECK FAILED %s %s: expected %0d actual %0d", name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic add_test(input string name, input fpsu_pkg::fop_e op,
                          input logic [63:0] a, input logic [63:0] b,
                          input logic [1:0] src_a, input logic [1:0] src_b,
                          input logic [3:0] csr_bits, input logic [63:0] data,
                          input logic [3:0] cmp, input logic ret_en,
                          input fpsu_pkg::exc_code_e code);
    test_t t;
    t.req.op       = op;
    t.req.a        = a;
    t.req.b        = b;
    t.req.src_a    = src_a;
    t.req.src_b    = src_b;
    t.csr          = csr_bits;
    t.exp.data     = data;
    t.exp.cmp      = cmp;
    t.exp.ret_en   = ret_en;
    t.exp.ret_code = code;
    tests.push_back(t);
    names.push_back(name);
  endtask

  // csr bits are invalid, overflow, underflow, inexact; cmp bits are lt, eq, gt, unord
  task automatic build_table();
    add_test("adds 1.5+2.25", fpsu_pkg::FOP_ADDS, 64'h40000000_3fc00000, 64'h40000000_40100000,
             2'd0, 2'd0, 4'b1111, 64'h00000000_40700000, 4'b0000, 1'b0, fpsu_pkg::EXC_NONE);
    add_test("subs 1.0-0.75", fpsu_pkg::FOP_SUBS, 64'h3f800000_3f800000, 64'h3f800000_3f400000,
             2'd0, 2'd0, 4'b1111, 64'h00000000_3e800000, 4'b0000, 1'b0, fpsu_pkg::EXC_NONE);
    add_test("addsp ties to even", fpsu_pkg::FOP_ADDSP, 64'h3f800000_3f800000,
             64'h34400000_33800000, 2'd0, 2'd0, 4'b0001, 64'h3f800002_3f800000, 4'b0000,
             1'b1, fpsu_pkg::EXC_INEXACT);
    add_test("subsp exact", fpsu_pkg::FOP_SUBSP, 64'h3f800000_40700000, 64'h40100000_3fc00000,
             2'd0, 2'd0, 4'b1111, 64'hbfa00000_40100000, 4'b0000, 1'b0, fpsu_pkg::EXC_NONE);
    add_test("fwd bus0/bus1", fpsu_pkg::FOP_ADDS, 64'h40000000_3fc00000, 64'h40000000_40100000,
             2'd1, 2'd2, 4'b1111, 64'h00000000_40700000, 4'b0000, 1'b0, fpsu_pkg::EXC_NONE);
    add_test("fwd bus2/reg", fpsu_pkg::FOP_ADDS, 64'h40000000_3fc00000, 64'h40000000_40100000,
             2'd3, 2'd0, 4'b1111, 64'h00000000_40700000, 4'b0000, 1'b0, fpsu_pkg::EXC_NONE);
    add_test("fwd bus1/bus2", fpsu_pkg::FOP_ADDS, 64'h40000000_3fc00000, 64'h40000000_40100000,
             2'd2, 2'd3, 4'b1111, 64'h00000000_40700000, 4'b0000, 1'b0, fpsu_pkg::EXC_NONE);
    add_test("cmps 1.0<2.25", fpsu_pkg::FOP_CMPS, 64'h0_3f800000, 64'h0_40100000,
             2'd0, 2'd0, 4'b1111, 64'h0, 4'b1000, 1'b0, fpsu_pkg::EXC_NONE);
    add_test("cmps -1.0>-2.25", fpsu_pkg::FOP_CMPS, 64'h0_bf800000, 64'h0_c0100000,
             2'd0, 2'd0, 4'b1111, 64'h0, 4'b0010, 1'b0, fpsu_pkg::EXC_NONE);
    add_test("cmps +0==-0", fpsu_pkg::FOP_CMPS, 64'h0_00000000, 64'h0_80000000,
             2'd0, 2'd0, 4'b1111, 64'h0, 4'b0100, 1'b0, fpsu_pkg::EXC_NONE);
    add_test("cmps nan", fpsu_pkg::FOP_CMPS, 64'h0_7fc00000, 64'h0_3f800000,
             2'd0, 2'd0, 4'b1000, 64'h0, 4'b0001, 1'b1, fpsu_pkg::EXC_INVALID);
    add_test("overflow ovf+inx", fpsu_pkg::FOP_ADDS, 64'h0_7f7fffff, 64'h0_7f7fffff,
             2'd0, 2'd0, 4'b0101, 64'h0_7f800000, 4'b0000, 1'b1, fpsu_pkg::EXC_OVERFLOW);
    add_test("overflow inx only", fpsu_pkg::FOP_ADDS, 64'h0_7f7fffff, 64'h0_7f7fffff,
             2'd0, 2'd0, 4'b0001, 64'h0_7f800000, 4'b0000, 1'b1, fpsu_pkg::EXC_INEXACT);
    add_test("overflow masked", fpsu_pkg::FOP_ADDS, 64'h0_7f7fffff, 64'h0_7f7fffff,
             2'd0, 2'd0, 4'b0000, 64'h0_7f800000, 4'b0000, 1'b0, fpsu_pkg::EXC_NONE);
    add_test("inf-inf", fpsu_pkg::FOP_SUBS, 64'h0_7f800000, 64'h0_7f800000,
             2'd0, 2'd0, 4'b1000, 64'h0_7fc00000, 4'b0000, 1'b1, fpsu_pkg::EXC_INVALID);
    add_test("underflow flush", fpsu_pkg::FOP_SUBS, 64'h0_00800000, 64'h0_00c00000,
             2'd0, 2'd0, 4'b0011, 64'h0_80000000, 4'b0000, 1'b1, fpsu_pkg::EXC_UNDERFLOW);
    add_test("unknown op", fpsu_pkg::fop_e'(3'd7), 64'h0_7f7fffff, 64'h0_7f7fffff,
             2'd0, 2'd0, 4'b1111, 64'h0, 4'b0000, 1'b0, fpsu_pkg::EXC_NONE);
  endtask

  task automatic check_res(input string name, input test_t t);
    check_vec(name, t.exp.data, res.data);
    check_cmp(name, t.exp.cmp, res.cmp);
    check_code(name, t.exp.ret_en, t.exp.ret_code, res.ret_en, res.ret_code);
  endtask

  task automatic run_test(input int idx);
    test_t                          t;
    fpsu_pkg::fp_req_t              req_n;
    fpsu_pkg::vec_t [FWD_COUNT-1:0] bus_n;
    fpsu_pkg::vec_t                 rnd;
    logic [1:0]                     sel;
    int                             cycles;

    t     = tests[idx];
    req_n = t.req;
    for (int k = 0; k < FWD_COUNT; k++) begin
      random_vec(rnd);
      bus_n[k] = rnd;
    end
    if (t.req.src_a != 2'd0) begin
      random_vec(rnd);
      req_n.a    = rnd;  // register value must be ignored
      sel        = t.req.src_a - 2'd1;
      bus_n[sel] = t.req.a;
    end
    if (t.req.src_b != 2'd0) begin
      random_vec(rnd);
      req_n.b    = rnd;
      sel        = t.req.src_b - 2'd1;
      bus_n[sel] = t.req.b;
    end

    @(posedge clk);
    request <= req_n;
    fwd_bus <= bus_n;
    csr     <= t.csr;
    req     <= 1'b1;
    for (cycles = 1; cycles <= TIMEOUT; cycles++) begin
      @(negedge clk);
      if (ack) break;
    end
    if (!ack) begin
      $display("timeout in %s: ack never rose after req was raised", names[idx]);
      timed_out = 1'b1;
      return;
    end
    // drive edge and sampling edge come first
    check_count(names[idx], "ack rise cycles", ACK_LAT, cycles - 2);
    check_res(names[idx], t);

    repeat (HOLD_CYCLES) begin  // back-pressure
      @(negedge clk);
      check_bit(names[idx], "ack held", 1'b1, ack);
      check_res(names[idx], t);
    end

    @(posedge clk);
    req <= 1'b0;
    for (cycles = 1; cycles <= TIMEOUT; cycles++) begin
      @(negedge clk);
      if (!ack) break;
    end
    if (ack) begin
      $display("timeout in %s: ack never fell after req was lowered", names[idx]);
      timed_out = 1'b1;
      return;
    end
    check_count(names[idx], "ack fall cycles", 1, cycles - 2);
  endtask

  initial begin
    rst          = 1'b1;
    req          = 1'b0;
    request      = '0;
    fwd_bus      = '0;
    csr          = '0;
    run_count    = 0;
    failed_tests = 0;
    timed_out    = 1'b0;
    build_table();

    repeat (5) @(posedge clk);
    rst <= 1'b0;

    test_errs = 0;
    repeat (3) begin
      @(negedge clk);
      check_bit("reset idle", "ack", 1'b0, ack);
      check_vec("reset idle", '0, res.data);
      check_cmp("reset idle", '0, res.cmp);
      check_code("reset idle", 1'b0, fpsu_pkg::EXC_NONE, res.ret_en, res.ret_code);
    end
    run_count++;
    if (test_errs != 0) failed_tests++;
    $display("%s reset idle", (test_errs == 0) ? "PASS" : "FAIL");

    for (int i = 0; i < tests.size(); i++) begin
      test_errs = 0;
      run_test(i);
      if (timed_out) test_errs++;
      run_count++;
      if (test_errs != 0) failed_tests++;
      $display("%s %s", (test_errs == 0) ? "PASS" : "FAIL", names[i]);
      if (timed_out) break;
    end

    $display("tests run %0d, failed %0d", run_count, failed_tests);
    if (failed_tests == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
